/* Makefile */
SRCS := $(shell cat alu_top.f)

obj_dir/Valu_tb: alu_top.f $(SRCS)
	verilator --binary --top-module alu_tb -f alu_top.f -o Valu_tb

run: obj_dir/Valu_tb
	obj_dir/Valu_tb > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* alu_top.f */
logic/alu_cfg_pkg.sv
logic/alu_op_pkg.sv
logic/alu_shift.sv
logic/alu_mul.sv
logic/alu_div.sv
logic/alu_top.sv
dv/alu_checker.sv
dv/alu_tb.sv

/* dv/alu_checker.sv */
module alu_checker
  import alu_cfg_pkg::*;
  import alu_op_pkg::*;
(
  input  logic    clk,
  input  logic    reset_i,
  input  xlen_t   alu_a_i,
  input  xlen_t   alu_b_i,
  input  alu_op_t alu_op_i,
  input  logic    buff_valid_i,
  input  xlen_t   buff_i,
  input  logic    data_ready_i,
  input  xlen_t   alu_out_i,
  input  logic    stall_req_i,
  input  logic    compare_i,
  output int      errors_o,
  output int      checks_o
);

  int    err_count = 0;
  int    check_count = 0;
  xlen_t expected;

  assign errors_o = err_count;
  assign checks_o = check_count;

  function automatic xlen_t sext32(input logic [31:0] v);
    return {{(XLEN-32){v[31]}}, v};
  endfunction

  function automatic xlen_t ref_result(input alu_op_t op, input xlen_t a, input xlen_t b);
    logic signed [XLEN-1:0] sa, sb, dv, sq, sr;
    logic signed [31:0]     sa32, sb32, dv32, sq32, sr32;
    xlen_t                  udv;
    logic [31:0]            udv32;
    dxlen_t                 prod;
    logic                   zero_div, zero32, s1, s2;
    sa       = a;
    sb       = b;
    sa32     = a[31:0];
    sb32     = b[31:0];
    zero_div = (b == '0);
    zero32   = (b[31:0] == '0);
    // most negative over minus one divides by one instead, same quotient and remainder
    dv    = (zero_div || (a == {1'b1, {(XLEN-1){1'b0}}} && sb == -1)) ? 64'sd1 : sb;
    dv32  = (zero32 || (sa32 == 32'sh8000_0000 && sb32 == -1)) ? 32'sd1 : sb32;
    udv   = zero_div ? 64'd1 : b;
    udv32 = zero32 ? 32'd1 : b[31:0];
    sq    = sa / dv;
    sr    = sa % dv;  // sign follows the dividend
    sq32  = sa32 / dv32;
    sr32  = sa32 % dv32;
    s1    = (op == ALUOP_MULH) || (op == ALUOP_MULHSU);
    s2    = (op == ALUOP_MULH);
    prod  = {{XLEN{s1 & a[XLEN-1]}}, a} * {{XLEN{s2 & b[XLEN-1]}}, b};
    case (op)
      ALUOP_ADD:   return a + b;
      ALUOP_SUB:   return a - b;
      ALUOP_XOR:   return a ^ b;
      ALUOP_OR:    return a | b;
      ALUOP_AND:   return a & b;
      ALUOP_SLL:   return a << b[5:0];
      ALUOP_SRL:   return a >> b[5:0];
      ALUOP_SRA:   return sa >>> b[5:0];
      ALUOP_SLLW:  return sext32(a[31:0] << b[4:0]);
      ALUOP_SRLW:  return sext32(a[31:0] >> b[4:0]);
      ALUOP_SRAW:  return sext32(sa32 >>> b[4:0]);
      ALUOP_SLT, ALUOP_BLT:   return xlen_t'(sa < sb);
      ALUOP_SLTU, ALUOP_BLTU: return xlen_t'(a < b);
      ALUOP_BEQ:   return xlen_t'(a == b);
      ALUOP_BNE:   return xlen_t'(a != b);
      ALUOP_BGE:   return xlen_t'(sa >= sb);
      ALUOP_BGEU:  return xlen_t'(a >= b);
      ALUOP_MUL:   return a * b;
      ALUOP_MULH, ALUOP_MULHSU, ALUOP_MULHU: return prod[2*XLEN-1:XLEN];
      ALUOP_MULW:  return {32'd0, prod[31:0]};  // no sign extension here
      ALUOP_DIV:   return zero_div ? '1 : sq;
      ALUOP_DIVU:  return zero_div ? '1 : a / udv;
      ALUOP_REM:   return zero_div ? a : sr;
      ALUOP_REMU:  return zero_div ? a : a % udv;
      ALUOP_DIVW:  return zero32 ? '1 : sext32(sq32);
      ALUOP_DIVUW: return zero32 ? '1 : sext32(a[31:0] / udv32);
      ALUOP_REMW:  return zero32 ? sext32(a[31:0]) : sext32(sr32);
      ALUOP_REMUW: return sext32(zero32 ? a[31:0] : a[31:0] % udv32);
      default:     return '0;
    endcase
  endfunction

  function automatic string test_name(input alu_op_t op);
    string grp;
    if (op >= ALUOP_DIV && op <= ALUOP_REMUW) grp = "divide";
    else if (op >= ALUOP_MUL && op <= ALUOP_MULW) grp = "multiply";
    else if (op >= ALUOP_SLT && op <= ALUOP_BGEU) grp = "compare";
    else if (op >= ALUOP_SLL && op <= ALUOP_SRAW) grp = "shift";
    else grp = "arith";
    return $sformatf("%s op %0d", grp, op);
  endfunction

  task automatic compare_value(input string what, input xlen_t exp_v, input xlen_t act_v);
    check_count++;
    if (exp_v !== act_v) begin
      err_count++;
      $display("mismatch: %s %s expected %h actual %h", test_name(alu_op_i), what,
               exp_v, act_v);
    end
  endtask

  task automatic flag_error(input string msg);
    err_count++;
    $display("error: %s during %s", msg, test_name(alu_op_i));
  endtask

  always @(posedge clk) begin
    expected = ref_result(alu_op_i, alu_a_i, alu_b_i);
    if (!reset_i) begin
      if (alu_op_i >= ALUOP_MUL && alu_op_i <= ALUOP_REMUW) begin
        if (data_ready_i) begin
          compare_value("result", expected, alu_out_i);
          if (stall_req_i) flag_error("stall still high in the ready cycle");
        end else if (buff_valid_i) begin
          compare_value("buffer", buff_i, alu_out_i);  // buffer shown while held
        end else if (!stall_req_i) begin
          flag_error("stall low while the result is still pending");
        end
      end else begin
        if (stall_req_i || data_ready_i) flag_error("stall or ready raised for a single-cycle op");
        if (!stall_req_i && !buff_valid_i) begin
          compare_value("result", expected, alu_out_i);
          if (alu_op_i >= ALUOP_SLT && alu_op_i <= ALUOP_BGEU)
            compare_value("compare flag", expected, xlen_t'(compare_i));
        end
      end
    end
  end

endmodule

/* dv/alu_tb.sv */
module alu_tb
  import alu_cfg_pkg::*;
  import alu_op_pkg::*;
();

  localparam int READY_TIMEOUT = 200;  // cycles allowed before a missing ready pulse counts

  // zero, all ones, most negative, one, word most negative, most positive
  localparam xlen_t CORNERS [6] = '{64'd0, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
                                    64'd1, 64'h0000_0000_8000_0000, 64'h7fff_ffff_ffff_ffff};

  logic        clk;
  logic        reset;
  xlen_t       alu_a, alu_b, alu_out, buff_data;
  alu_op_t     alu_op;
  logic        buff_valid, data_ready, stall_req, compare_out;
  int          errors, checks;
  int          timeouts;
  logic [31:0] lcg_state;

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic xlen_t rand64();
    logic [31:0] hi;
    hi = lcg_next(lcg_state);
    lcg_state = lcg_next(hi);
    return {hi, lcg_state};
  endfunction

  // drives one op and for mul/div waits for ready and feeds the buffer back
  task automatic run_op(input alu_op_t op, input xlen_t a, input xlen_t b);
    int    waited;
    xlen_t captured;
    @(negedge clk);
    alu_op     = op;
    alu_a      = a;
    alu_b      = b;
    buff_valid = 1'b0;
    if (op >= ALUOP_MUL) begin
      waited = 0;
      @(negedge clk);
      while (!data_ready && waited < READY_TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (data_ready) begin
        captured = alu_out;
        @(negedge clk);
        buff_data  = captured;
        buff_valid = 1'b1;  // held until the op changes
        @(negedge clk);
      end else begin
        $display("timeout: no ready pulse within %0d cycles for op %0d", READY_TIMEOUT, op);
        timeouts++;
      end
    end
  endtask

  alu_top DUT (
    .clk                  (clk),
    .reset_i              (reset),
    .alu_a_i              (alu_a),
    .alu_b_i              (alu_b),
    .alu_op_i             (alu_op),
    .alu_data_buff_valid_i(buff_valid),
    .alu_data_buff_i      (buff_data),
    .alu_data_ready_o     (data_ready),
    .alu_out_o            (alu_out),
    .alu_stall_req_o      (stall_req),
    .compare_out_o        (compare_out)
  );

  alu_checker chk (
    .clk         (clk),
    .reset_i     (reset),
    .alu_a_i     (alu_a),
    .alu_b_i     (alu_b),
    .alu_op_i    (alu_op),
    .buff_valid_i(buff_valid),
    .buff_i      (buff_data),
    .data_ready_i(data_ready),
    .alu_out_i   (alu_out),
    .stall_req_i (stall_req),
    .compare_i   (compare_out),
    .errors_o    (errors),
    .checks_o    (checks)
  );

  initial begin
    alu_op_t op;
    int      i;
    int      j;
    xlen_t   a;
    xlen_t   b;
    clk        = 1'b0;
    reset      = 1'b1;
    alu_a      = '0;
    alu_b      = '0;
    alu_op     = ALUOP_ADD;
    buff_valid = 1'b0;
    buff_data  = '0;
    timeouts   = 0;
    lcg_state  = 32'h8c14;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    run_op(ALUOP_SRL, 64'hff, 64'd4);  // single-cycle op straight out of reset
    for (op = ALUOP_ADD; op <= ALUOP_REMUW && timeouts == 0; op++) begin
      for (i = 0; i < 6 && timeouts == 0; i++) begin
        for (j = 0; j < 6 && timeouts == 0; j++) begin
          run_op(op, CORNERS[i], CORNERS[j]);
        end
      end
      for (i = 0; i < 64 && timeouts == 0; i++) begin
        a = rand64();
        b = rand64();
        if (i % 8 == 0) b = a;  // equal operands
        if (op >= ALUOP_DIV) b = b >> lcg_state[5:0];  // spread divisor sizes
        if (op >= ALUOP_SLL && op <= ALUOP_SRAW) b[SHAMT_W-1:0] = shamt_t'(i);
        run_op(op, a, b);
      end
    end
    @(negedge clk);
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* logic/alu_cfg_pkg.sv */
package alu_cfg_pkg;

  // integer datapath of the rv64 execute unit
  localparam int XLEN = 64;

  // shift amount and step counters cover one full operand
  localparam int SHAMT_W = 6;

  // one operand or one result
  typedef logic [XLEN-1:0] xlen_t;

  typedef logic [2*XLEN-1:0] dxlen_t;  // full multiply product

  typedef logic [SHAMT_W-1:0] shamt_t;  // 6 bits, word shifts use only 5

endpackage

/* logic/alu_div.sv */
module alu_div
  import alu_cfg_pkg::*;
(
  input  logic  clk,
  input  logic  reset_i,
  input  logic  signed_i,
  input  logic  div32_i,
  input  xlen_t sr1_data_i,
  input  xlen_t sr2_data_i,
  input  logic  div_valid_i,
  output logic  div_ready_o,
  output xlen_t div_out_o,
  output xlen_t rem_out_o
);

  typedef enum logic [1:0] {DIV_IDLE, DIV_BUSY, DIV_FIX, DIV_DONE} div_state_e;

  div_state_e         state_q;
  logic [SHAMT_W-1:0] step_q;

  xlen_t dividend_q;  // extended dividend, reused by the corner cases
  xlen_t dmag_q;      // divisor magnitude
  xlen_t quo_q;       // dividend bits leave as quotient bits enter
  xlen_t part_q;      // partial remainder
  logic  q_neg_q, r_neg_q, zero_q, ovf_q, div32_q;

  xlen_t         a_ext, b_ext, min_val;
  logic          a_neg, b_neg, start;
  logic [XLEN:0] shifted, trial;
  logic          fits;
  xlen_t         fix_quo, fix_rem;

  // word forms take the low halves, extended by signedness
  always_comb begin
    a_ext = sr1_data_i;
    b_ext = sr2_data_i;
    if (div32_i) begin
      a_ext = {{(XLEN-32){signed_i & sr1_data_i[31]}}, sr1_data_i[31:0]};
      b_ext = {{(XLEN-32){signed_i & sr2_data_i[31]}}, sr2_data_i[31:0]};
    end
  end

  assign a_neg   = signed_i & a_ext[XLEN-1];
  assign b_neg   = signed_i & b_ext[XLEN-1];
  assign min_val = div32_i ? {{(XLEN-31){1'b1}}, 31'b0} : {1'b1, {(XLEN-1){1'b0}}};
  assign start   = (state_q == DIV_IDLE) & div_valid_i;

  // one restoring step
  assign shifted = {part_q, quo_q[XLEN-1]};
  assign fits    = (shifted >= {1'b0, dmag_q});
  assign trial   = shifted - {1'b0, dmag_q};

  always_comb begin
    if (zero_q) begin
      fix_quo = '1;
      fix_rem = dividend_q;
    end else if (ovf_q) begin
      fix_quo = dividend_q;  // most negative passes through
      fix_rem = '0;
    end else begin
      fix_quo = q_neg_q ? -quo_q : quo_q;
      fix_rem = r_neg_q ? -part_q : part_q;
    end
    if (div32_q) begin
      fix_quo = {{(XLEN-32){fix_quo[31]}}, fix_quo[31:0]};
      fix_rem = {{(XLEN-32){fix_rem[31]}}, fix_rem[31:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= DIV_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        DIV_IDLE: if (div_valid_i) begin
          state_q <= DIV_BUSY;
          step_q  <= '0;
        end
        DIV_BUSY: begin
          step_q <= step_q + SHAMT_W'(1);
          if (step_q == SHAMT_W'(XLEN-1)) state_q <= DIV_FIX;
        end
        DIV_FIX: state_q <= DIV_DONE;
        DIV_DONE: if (!div_valid_i) state_q <= DIV_IDLE;
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      dividend_q <= a_ext;
      dmag_q     <= b_neg ? -b_ext : b_ext;
      quo_q      <= a_neg ? -a_ext : a_ext;
      part_q     <= '0;
      q_neg_q    <= a_neg ^ b_neg;
      r_neg_q    <= a_neg;  // remainder follows the dividend
      zero_q     <= (b_ext == '0);
      ovf_q      <= signed_i & (a_ext == min_val) & (b_ext == '1);
      div32_q    <= div32_i;
    end else if (state_q == DIV_BUSY) begin
      part_q <= fits ? trial[XLEN-1:0] : shifted[XLEN-1:0];
      quo_q  <= {quo_q[XLEN-2:0], fits};
    end else if (state_q == DIV_FIX) begin
      quo_q  <= fix_quo;
      part_q <= fix_rem;
    end
  end

  assign div_ready_o = (state_q == DIV_DONE);
  assign div_out_o   = quo_q;
  assign rem_out_o   = part_q;

endmodule

/* logic/alu_mul.sv */
module alu_mul
  import alu_cfg_pkg::*;
(
  input  logic   clk,
  input  logic   reset_i,
  input  logic   rs1_signed_i,
  input  logic   rs2_signed_i,
  input  xlen_t  rs1_data_i,
  input  xlen_t  rs2_data_i,
  input  logic   mul_valid_i,
  output logic   mul_ready_o,
  output dxlen_t mul_out_o
);

  typedef enum logic [1:0] {MUL_IDLE, MUL_BUSY, MUL_DONE} mul_state_e;

  mul_state_e         state_q;
  logic [SHAMT_W-1:0] step_q;

  xlen_t  mcand_q;  // multiplicand magnitude
  dxlen_t prod_q;   // partial sum on top, unused multiplier bits below
  logic   neg_q;

  logic          rs1_neg, rs2_neg;
  logic          start;
  logic [XLEN:0] step_sum;

  assign rs1_neg = rs1_signed_i & rs1_data_i[XLEN-1];
  assign rs2_neg = rs2_signed_i & rs2_data_i[XLEN-1];
  assign start   = (state_q == MUL_IDLE) & mul_valid_i;

  // add the multiplicand when the current multiplier bit is set
  assign step_sum = {1'b0, prod_q[2*XLEN-1:XLEN]} + (prod_q[0] ? {1'b0, mcand_q} : '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= MUL_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        MUL_IDLE: if (mul_valid_i) begin
          state_q <= MUL_BUSY;
          step_q  <= '0;
        end
        MUL_BUSY: begin
          step_q <= step_q + SHAMT_W'(1);
          if (step_q == SHAMT_W'(XLEN-1)) state_q <= MUL_DONE;  // 64 steps
        end
        MUL_DONE: if (!mul_valid_i) state_q <= MUL_IDLE;
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      mcand_q <= rs1_neg ? -rs1_data_i : rs1_data_i;
      prod_q  <= {{XLEN{1'b0}}, (rs2_neg ? -rs2_data_i : rs2_data_i)};
      neg_q   <= rs1_neg ^ rs2_neg;
    end else if (state_q == MUL_BUSY) begin
      prod_q <= {step_sum, prod_q[XLEN-1:1]};  // shift right one bit
    end
  end

  assign mul_ready_o = (state_q == MUL_DONE);
  assign mul_out_o   = neg_q ? -prod_q : prod_q;  // sign put back in done

endmodule

/* logic/alu_op_pkg.sv */
package alu_op_pkg;

  localparam int ALUOP_LEN = 6;

  typedef logic [ALUOP_LEN-1:0] alu_op_t;

  // code 0 is left free and yields a zero result

  // add, sub and logic
  localparam alu_op_t ALUOP_ADD    = 6'd1;
  localparam alu_op_t ALUOP_SUB    = 6'd2;
  localparam alu_op_t ALUOP_XOR    = 6'd3;
  localparam alu_op_t ALUOP_OR     = 6'd4;
  localparam alu_op_t ALUOP_AND    = 6'd5;
  // shifts
  localparam alu_op_t ALUOP_SLL    = 6'd6;
  localparam alu_op_t ALUOP_SRL    = 6'd7;
  localparam alu_op_t ALUOP_SRA    = 6'd8;
  localparam alu_op_t ALUOP_SLLW   = 6'd9;
  localparam alu_op_t ALUOP_SRLW   = 6'd10;
  localparam alu_op_t ALUOP_SRAW   = 6'd11;
  // set less than
  localparam alu_op_t ALUOP_SLT    = 6'd12;
  localparam alu_op_t ALUOP_SLTU   = 6'd13;
  // branch compares
  localparam alu_op_t ALUOP_BEQ    = 6'd14;
  localparam alu_op_t ALUOP_BNE    = 6'd15;
  localparam alu_op_t ALUOP_BLT    = 6'd16;
  localparam alu_op_t ALUOP_BGE    = 6'd17;
  localparam alu_op_t ALUOP_BLTU   = 6'd18;
  localparam alu_op_t ALUOP_BGEU   = 6'd19;
  // multiply
  localparam alu_op_t ALUOP_MUL    = 6'd20;
  localparam alu_op_t ALUOP_MULH   = 6'd21;
  localparam alu_op_t ALUOP_MULHSU = 6'd22;
  localparam alu_op_t ALUOP_MULHU  = 6'd23;
  localparam alu_op_t ALUOP_MULW   = 6'd24;
  // divide and remainder
  localparam alu_op_t ALUOP_DIV    = 6'd25;
  localparam alu_op_t ALUOP_DIVU   = 6'd26;
  localparam alu_op_t ALUOP_REM    = 6'd27;
  localparam alu_op_t ALUOP_REMU   = 6'd28;
  localparam alu_op_t ALUOP_DIVW   = 6'd29;
  localparam alu_op_t ALUOP_DIVUW  = 6'd30;
  localparam alu_op_t ALUOP_REMW   = 6'd31;
  localparam alu_op_t ALUOP_REMUW  = 6'd32;

endpackage

/* logic/alu_shift.sv */
module alu_shift
  import alu_cfg_pkg::*;
(
  input  logic   shift_sll_i,
  input  logic   shift_srl_i,
  input  logic   shift_sra_i,
  input  logic   shift32_i,      // word form
  input  xlen_t  shift_num_i,
  input  shamt_t shift_count_i,
  output xlen_t  shift_out_o
);

  xlen_t  src;
  shamt_t amt;
  xlen_t  res;

  always_comb begin
    // word forms only see the low half of the operand
    if (shift32_i) begin
      src = shift_sra_i ? {{(XLEN-32){shift_num_i[31]}}, shift_num_i[31:0]}
                        : {{(XLEN-32){1'b0}}, shift_num_i[31:0]};
      amt = {1'b0, shift_count_i[4:0]};  // 5-bit amount
    end else begin
      src = shift_num_i;
      amt = shift_count_i;
    end

    res = ({XLEN{shift_sll_i}} & (src << amt))
        | ({XLEN{shift_srl_i}} & (src >> amt))
        | ({XLEN{shift_sra_i}} & xlen_t'($signed(src) >>> amt));

    // result of a word shift is sign-extended from bit 31
    shift_out_o = shift32_i ? {{(XLEN-32){res[31]}}, res[31:0]} : res;
  end

endmodule

/* logic/alu_top.sv */
module alu_top
  import alu_cfg_pkg::*;
  import alu_op_pkg::*;
(
  input  logic    clk,
  input  logic    reset_i,
  input  xlen_t   alu_a_i,
  input  xlen_t   alu_b_i,
  input  alu_op_t alu_op_i,
  input  logic    alu_data_buff_valid_i,  // captured mul/div result is valid
  input  xlen_t   alu_data_buff_i,
  output logic    alu_data_ready_o,
  output xlen_t   alu_out_o,
  output logic    alu_stall_req_o,
  output logic    compare_out_o
);

  // add, sub and logic
  wire op_add = (alu_op_i == ALUOP_ADD);
  wire op_sub = (alu_op_i == ALUOP_SUB);
  wire op_xor = (alu_op_i == ALUOP_XOR);
  wire op_or  = (alu_op_i == ALUOP_OR);
  wire op_and = (alu_op_i == ALUOP_AND);
  // shifts with the word forms folded in
  wire op_sll     = alu_op_i inside {ALUOP_SLL, ALUOP_SLLW};
  wire op_srl     = alu_op_i inside {ALUOP_SRL, ALUOP_SRLW};
  wire op_sra     = alu_op_i inside {ALUOP_SRA, ALUOP_SRAW};
  wire op_shift32 = alu_op_i inside {ALUOP_SLLW, ALUOP_SRLW, ALUOP_SRAW};
  // compares
  wire op_lt   = alu_op_i inside {ALUOP_SLT, ALUOP_BLT};
  wire op_ltu  = alu_op_i inside {ALUOP_SLTU, ALUOP_BLTU};
  wire op_beq  = (alu_op_i == ALUOP_BEQ);
  wire op_bne  = (alu_op_i == ALUOP_BNE);
  wire op_bge  = (alu_op_i == ALUOP_BGE);
  wire op_bgeu = (alu_op_i == ALUOP_BGEU);
  wire is_cmp  = op_lt | op_ltu | op_beq | op_bne | op_bge | op_bgeu;
  // multiply
  wire op_mul_lo  = (alu_op_i == ALUOP_MUL);
  wire op_mul_hi  = alu_op_i inside {ALUOP_MULH, ALUOP_MULHSU, ALUOP_MULHU};
  wire op_mulw    = (alu_op_i == ALUOP_MULW);
  wire is_mul     = op_mul_lo | op_mul_hi | op_mulw;
  wire mul_s1     = alu_op_i inside {ALUOP_MUL, ALUOP_MULH, ALUOP_MULHSU, ALUOP_MULW};
  wire mul_s2     = alu_op_i inside {ALUOP_MUL, ALUOP_MULH, ALUOP_MULW};
  // divide
  wire op_quot    = alu_op_i inside {ALUOP_DIV, ALUOP_DIVU, ALUOP_DIVW, ALUOP_DIVUW};
  wire op_rem     = alu_op_i inside {ALUOP_REM, ALUOP_REMU, ALUOP_REMW, ALUOP_REMUW};
  wire is_div     = op_quot | op_rem;
  wire div_signed = alu_op_i inside {ALUOP_DIV, ALUOP_REM, ALUOP_DIVW, ALUOP_REMW};
  wire div_word   = alu_op_i inside {ALUOP_DIVW, ALUOP_DIVUW, ALUOP_REMW, ALUOP_REMUW};

  // 65-bit adder with one extra sign bit on each operand
  wire           is_sub  = op_sub | is_cmp;
  wire [XLEN:0]  add_a   = {alu_a_i[XLEN-1], alu_a_i};
  wire [XLEN:0]  add_b   = {alu_b_i[XLEN-1], alu_b_i} ^ {(XLEN+1){is_sub}};
  wire [XLEN:0]  add_sum = add_a + add_b + {{XLEN{1'b0}}, is_sub};

  wire flag_zero = (add_sum[XLEN-1:0] == '0);
  wire flag_sign = add_sum[XLEN-1];
  wire flag_ovf  = add_sum[XLEN] ^ add_sum[XLEN-1];
  wire carry64   = add_a[XLEN] ^ add_b[XLEN] ^ add_sum[XLEN];  // carry out of bit 63
  wire lt_s      = flag_sign ^ flag_ovf;
  wire lt_u      = is_sub ^ carry64;  // no borrow means a >= b

  wire compare = (op_lt & lt_s) | (op_ltu & lt_u)
               | (op_beq & flag_zero) | (op_bne & ~flag_zero)
               | (op_bge & ~lt_s) | (op_bgeu & ~lt_u);

  wire xlen_t shift_res;

  alu_shift u_alu_shift (
    .shift_sll_i  (op_sll),
    .shift_srl_i  (op_srl),
    .shift_sra_i  (op_sra),
    .shift32_i    (op_shift32),
    .shift_num_i  (alu_a_i),
    .shift_count_i(alu_b_i[SHAMT_W-1:0]),
    .shift_out_o  (shift_res)
  );

  wire          mul_ready, div_ready;
  wire dxlen_t  mul_prod;
  wire xlen_t   div_quo, div_rem;

  // stall until the unit is ready or the buffer holds its result
  wire mul_stall = is_mul & ~mul_ready & ~alu_data_buff_valid_i;
  wire div_stall = is_div & ~div_ready & ~alu_data_buff_valid_i;

  alu_mul u_alu_mul (
    .clk         (clk),
    .reset_i     (reset_i),
    .rs1_signed_i(mul_s1),
    .rs2_signed_i(mul_s2),
    .rs1_data_i  (alu_a_i),
    .rs2_data_i  (alu_b_i),
    .mul_valid_i (mul_stall),
    .mul_ready_o (mul_ready),
    .mul_out_o   (mul_prod)
  );

  alu_div u_alu_div (
    .clk        (clk),
    .reset_i    (reset_i),
    .signed_i   (div_signed),
    .div32_i    (div_word),
    .sr1_data_i (alu_a_i),
    .sr2_data_i (alu_b_i),
    .div_valid_i(div_stall),
    .div_ready_o(div_ready),
    .div_out_o  (div_quo),
    .rem_out_o  (div_rem)
  );

  // mulw leaves sign extension to the execute stage
  wire xlen_t direct_res = ({XLEN{op_add | op_sub}} & add_sum[XLEN-1:0])
                         | ({XLEN{op_and}} & (alu_a_i & alu_b_i))
                         | ({XLEN{op_or}} & (alu_a_i | alu_b_i))
                         | ({XLEN{op_xor}} & (alu_a_i ^ alu_b_i))
                         | ({XLEN{op_sll | op_srl | op_sra}} & shift_res)
                         | ({XLEN{op_mul_lo}} & mul_prod[XLEN-1:0])
                         | ({XLEN{op_mul_hi}} & mul_prod[2*XLEN-1:XLEN])
                         | ({XLEN{op_mulw}} & {{(XLEN-32){1'b0}}, mul_prod[31:0]})
                         | ({XLEN{op_quot}} & div_quo)
                         | ({XLEN{op_rem}} & div_rem);

  // compare wins over the buffer which wins over the direct path
  assign alu_out_o = ({XLEN{is_cmp}} & {{(XLEN-1){1'b0}}, compare})
                   | ({XLEN{~is_cmp & alu_data_buff_valid_i}} & alu_data_buff_i)
                   | ({XLEN{~is_cmp & ~alu_data_buff_valid_i}} & direct_res);

  assign alu_data_ready_o = mul_ready | div_ready;
  assign alu_stall_req_o  = mul_stall | div_stall;
  assign compare_out_o    = compare;

endmodule
